/* include/video_config.svh */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// horizontal timing in pixels, visible part first
`define VID_H_VISIBLE       640
`define VID_H_FRONT         16
`define VID_H_SYNC          96
`define VID_H_TOTAL         800

// vertical timing in lines, visible part first
`define VID_V_VISIBLE       480
`define VID_V_FRONT         10
`define VID_V_SYNC          2
`define VID_V_TOTAL         525

`define VID_H_SYNC_POL      1'b0        // active low hsync
`define VID_V_SYNC_POL      1'b0        // active low vsync

// video half of the register map (bit 4 clear)
`define XR_VID_CTRL         5'h00
`define XR_SCANLINE         5'h03
`define XR_VID_LEFT         5'h04
`define XR_VID_RIGHT        5'h05
`define XR_VID_HSIZE        5'h08
`define XR_VID_VSIZE        5'h09

// playfield half of the register map (bit 4 set)
`define XR_PA_GFX_CTRL      5'h10
`define XR_PA_DISP_ADDR     5'h12
`define XR_PA_LINE_LEN      5'h13

`define RST_BORDER_COLOR    8'h08       // dark grey, shows the display is alive
`define RST_LINE_LEN        16'd80

`endif

/* hw/video_pkg.sv */
`default_nettype none

package video_pkg;

    // register port data word
    typedef logic [15:0] word_t;

    // video memory word address (64K words)
    typedef logic [15:0] addr_t;

    // palette index driven to the colour lookup
    typedef logic [7:0] color_t;

    // pixel position within a line, covers the full line total
    typedef logic [9:0] hres_t;

    // line number within a frame, covers the full frame total
    typedef logic [9:0] vres_t;

    // register number on the register port
    typedef logic [4:0] reg_num_t;

    // phases of one line or one frame, in scan order
    typedef enum logic [1:0] {
        VISIBLE   = 2'b00,
        PRE_SYNC  = 2'b01,      // front porch
        SYNC      = 2'b10,
        POST_SYNC = 2'b11       // back porch
    } timing_state_t;

endpackage

`default_nettype wire

/* hw/video_timing.sv */
`default_nettype none
`timescale 1ns/100ps

`include "video_config.svh"

module video_timing
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    output hres_t           h_count_o,
    output vres_t           v_count_o,
    output timing_state_t   h_state_next_o,
    output timing_state_t   v_state_next_o,
    output logic            v_visible_o,
    output logic            line_end_o,         // last visible pixel of a line
    output logic            frame_end_o         // last pixel of the frame
);

    timing_state_t  h_state;
    timing_state_t  v_state;
    timing_state_t  h_follow;                   // state after the current one
    timing_state_t  v_follow;
    hres_t          h_end;                      // last count of current h state
    vres_t          v_end;                      // last line of current v state
    logic           line_wrap;                  // last pixel of the whole line

    always_comb begin
        case (h_state)
            VISIBLE: begin
                h_end    = hres_t'(`VID_H_VISIBLE - 1);
                h_follow = PRE_SYNC;
            end
            PRE_SYNC: begin
                h_end    = hres_t'(`VID_H_VISIBLE + `VID_H_FRONT - 1);
                h_follow = SYNC;
            end
            SYNC: begin
                h_end    = hres_t'(`VID_H_VISIBLE + `VID_H_FRONT + `VID_H_SYNC - 1);
                h_follow = POST_SYNC;
            end
            default: begin
                h_end    = hres_t'(`VID_H_TOTAL - 1);
                h_follow = VISIBLE;
            end
        endcase
    end

    always_comb begin
        case (v_state)
            VISIBLE: begin
                v_end    = vres_t'(`VID_V_VISIBLE - 1);
                v_follow = PRE_SYNC;
            end
            PRE_SYNC: begin
                v_end    = vres_t'(`VID_V_VISIBLE + `VID_V_FRONT - 1);
                v_follow = SYNC;
            end
            SYNC: begin
                v_end    = vres_t'(`VID_V_VISIBLE + `VID_V_FRONT + `VID_V_SYNC - 1);
                v_follow = POST_SYNC;
            end
            default: begin
                v_end    = vres_t'(`VID_V_TOTAL - 1);
                v_follow = VISIBLE;
            end
        endcase
    end

    assign line_wrap      = (h_count_o == hres_t'(`VID_H_TOTAL - 1));
    assign h_state_next_o = (h_count_o == h_end) ? h_follow : h_state;
    assign v_state_next_o = (line_wrap && v_count_o == v_end) ? v_follow : v_state;

    assign v_visible_o = (v_state == VISIBLE);
    assign line_end_o  = (h_state == VISIBLE) && (h_state_next_o == PRE_SYNC);
    assign frame_end_o = line_wrap && (v_state == POST_SYNC) && (v_state_next_o == VISIBLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count_o <= '0;
            v_count_o <= '0;
            h_state   <= VISIBLE;
            v_state   <= VISIBLE;
        end else begin
            h_state <= h_state_next_o;
            v_state <= v_state_next_o;
            if (line_wrap) begin
                h_count_o <= '0;
                v_count_o <= frame_end_o ? vres_t'(0) : v_count_o + 1'b1;
            end else begin
                h_count_o <= h_count_o + 1'b1;
            end
        end
    end

    a_h_count_range: assert property (@(posedge clk) disable iff (reset_i)
        h_count_o < hres_t'(`VID_H_TOTAL))
        else $error("h_count passed the line total");

endmodule

`default_nettype wire

/* hw/video_regs.sv */
`default_nettype none
`timescale 1ns/100ps

`include "video_config.svh"

module video_regs
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,           // single cycle write strobe
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    output word_t           reg_data_o,         // readback of last cycle's reg_num_i
    input  wire logic [3:0] intr_status_i,      // pending interrupts, read only
    output logic [3:0]      intr_signal_o,
    input  wire logic       frame_vis_end_i,    // last visible pixel of the frame
    input  wire vres_t      v_count_i,
    input  wire logic       v_visible_i,
    output color_t          border_color_o,
    output hres_t           vid_left_o,
    output hres_t           vid_right_o,
    output logic            pa_blank_o,
    output color_t          pa_colorbase_o,
    output addr_t           pa_start_addr_o,
    output word_t           pa_line_len_o
);

    word_t  rd_vid_regs;                        // readback, registers with bit 4 clear
    word_t  rd_pf_regs;                         // readback, registers with bit 4 set

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o   <= '0;
            border_color_o  <= `RST_BORDER_COLOR;
            vid_left_o      <= '0;
            vid_right_o     <= hres_t'(`VID_H_VISIBLE);    // window fully open
            pa_blank_o      <= 1'b1;                        // playfield starts blanked
            pa_colorbase_o  <= '0;
            pa_start_addr_o <= '0;
            pa_line_len_o   <= `RST_LINE_LEN;
        end else begin
            intr_signal_o <= '0;                // pulses last one cycle
            if (reg_wr_i) begin
                case (reg_num_i)
                    `XR_VID_CTRL: begin
                        border_color_o <= reg_data_i[15:8];
                        intr_signal_o  <= reg_data_i[3:0];  // software raised interrupts
                    end
                    `XR_VID_LEFT: begin
                        vid_left_o <= reg_data_i[9:0];
                    end
                    `XR_VID_RIGHT: begin
                        vid_right_o <= reg_data_i[9:0];
                    end
                    `XR_PA_GFX_CTRL: begin
                        pa_colorbase_o <= reg_data_i[15:8];
                        pa_blank_o     <= reg_data_i[7];
                    end
                    `XR_PA_DISP_ADDR: begin
                        pa_start_addr_o <= reg_data_i;
                    end
                    `XR_PA_LINE_LEN: begin
                        pa_line_len_o <= reg_data_i;
                    end
                    default: begin
                    end
                endcase
            end
            if (frame_vis_end_i) begin
                intr_signal_o[3] <= 1'b1;       // vertical blank interrupt
            end
        end
    end

    // video half of the readback
    always_comb begin
        case (reg_num_i[3:0])
            4'(`XR_VID_CTRL):   rd_vid_regs = {border_color_o, 4'b0000, intr_status_i};
            4'(`XR_SCANLINE):   rd_vid_regs = {~v_visible_i, 15'(v_count_i)};
            4'(`XR_VID_HSIZE):  rd_vid_regs = word_t'(`VID_H_VISIBLE);
            4'(`XR_VID_VSIZE):  rd_vid_regs = word_t'(`VID_V_VISIBLE);
            default:            rd_vid_regs = '0;
        endcase
    end

    // playfield half of the readback
    always_comb begin
        case (reg_num_i[3:0])
            4'(`XR_PA_GFX_CTRL):    rd_pf_regs = {pa_colorbase_o, pa_blank_o, 7'b0000000};
            4'(`XR_PA_DISP_ADDR):   rd_pf_regs = pa_start_addr_o;
            4'(`XR_PA_LINE_LEN):    rd_pf_regs = pa_line_len_o;
            default:                rd_pf_regs = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_data_o <= reg_num_i[4] ? rd_pf_regs : rd_vid_regs;
    end

    a_reg_num_known: assert property (@(posedge clk) disable iff (reset_i)
        reg_wr_i |-> !$isunknown(reg_num_i))
        else $error("register write with unknown register number");

endmodule

`default_nettype wire

/* hw/bitmap_fetch.sv */
`default_nettype none
`timescale 1ns/100ps

`include "video_config.svh"

module bitmap_fetch
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire hres_t      h_count_i,
    input  wire logic       v_visible_i,
    input  wire logic       line_end_i,
    input  wire logic       frame_end_i,
    input  wire logic       h_visible_i,
    input  wire logic       pa_blank_i,
    input  wire addr_t      pa_start_addr_i,
    input  wire word_t      pa_line_len_i,      // stride in words
    output logic            vram_sel_o,
    output addr_t           vram_addr_o,
    output logic            byte_lo_o           // data at pixel_out belongs to odd pixel
);

    addr_t  line_addr;                          // first word of the current line

    // one word holds two 8-bit pixels, so fetch on even counts only
    assign vram_sel_o  = v_visible_i && h_visible_i && !h_count_i[0] && !pa_blank_i;
    assign vram_addr_o = line_addr + addr_t'(h_count_i[9:1]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr <= '0;
            byte_lo_o <= 1'b0;
        end else begin
            byte_lo_o <= h_count_i[0];          // follows the word into pixel_out
            if (frame_end_i) begin
                line_addr <= pa_start_addr_i;   // top of next frame
            end else if (line_end_i && v_visible_i) begin
                line_addr <= line_addr + pa_line_len_i;
            end
        end
    end

    a_sel_in_visible: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> (h_count_i < hres_t'(`VID_H_VISIBLE)) && v_visible_i)
        else $error("video memory read outside the visible area");

endmodule

`default_nettype wire

/* hw/pixel_out.sv */
`default_nettype none
`timescale 1ns/100ps

`include "video_config.svh"

module pixel_out
    import video_pkg::*;
(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire word_t          vram_data_i,    // even pixel high byte, odd pixel low byte
    input  wire logic           byte_lo_i,
    input  wire hres_t          h_count_i,
    input  wire timing_state_t  h_state_next_i,
    input  wire timing_state_t  v_state_next_i,
    input  wire color_t         border_color_i,
    input  wire hres_t          vid_left_i,
    input  wire hres_t          vid_right_i,
    input  wire logic           pa_blank_i,
    input  wire color_t         pa_colorbase_i,
    output color_t              colorA_index_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

    logic       in_window;                      // window test, aligned with the data
    logic       blank_d;                        // blank as seen by the fetch
    color_t     lo_byte;                        // odd pixel kept from the even cycle
    color_t     pix_index;
    logic [1:0] de_pipe;
    logic [1:0] hs_pipe;                        // 1 = sync active
    logic [1:0] vs_pipe;

    always_comb begin
        if (!in_window || blank_d) begin
            pix_index = border_color_i;
        end else if (byte_lo_i) begin
            pix_index = lo_byte ^ pa_colorbase_i;
        end else begin
            pix_index = vram_data_i[15:8] ^ pa_colorbase_i;
        end
    end

    always_ff @(posedge clk) begin
        in_window <= (h_count_i >= vid_left_i) && (h_count_i < vid_right_i);
        blank_d   <= pa_blank_i;
        if (!byte_lo_i) begin
            lo_byte <= vram_data_i[7:0];        // memory word is valid only this cycle
        end
    end

    // next states describe the following count, so three stages give two cycles of latency
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_pipe        <= '0;
            hs_pipe        <= '0;
            vs_pipe        <= '0;
            dv_de_o        <= 1'b0;
            hsync_o        <= ~`VID_H_SYNC_POL;
            vsync_o        <= ~`VID_V_SYNC_POL;
            colorA_index_o <= '0;
        end else begin
            de_pipe <= {de_pipe[0], (h_state_next_i == VISIBLE) && (v_state_next_i == VISIBLE)};
            hs_pipe <= {hs_pipe[0], h_state_next_i == SYNC};
            vs_pipe <= {vs_pipe[0], v_state_next_i == SYNC};
            dv_de_o <= de_pipe[1];
            hsync_o <= hs_pipe[1] ? `VID_H_SYNC_POL : ~`VID_H_SYNC_POL;
            vsync_o <= vs_pipe[1] ? `VID_V_SYNC_POL : ~`VID_V_SYNC_POL;
            colorA_index_o <= pix_index;
        end
    end

endmodule

`default_nettype wire

/* hw/video_gen.sv */
`default_nettype none
`timescale 1ns/100ps

`include "video_config.svh"

module video_gen
    import video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       reg_wr_i,
    input  wire reg_num_t   reg_num_i,
    input  wire word_t      reg_data_i,
    output word_t           reg_data_o,
    input  wire logic [3:0] intr_status_i,
    output logic [3:0]      intr_signal_o,
    output logic            vram_sel_o,
    output addr_t           vram_addr_o,
    input  wire word_t      vram_data_i,
    output color_t          colorA_index_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o
);

    hres_t          h_count;
    vres_t          v_count;
    timing_state_t  h_state_next;
    timing_state_t  v_state_next;
    logic           v_visible;
    logic           h_visible;
    logic           line_end;
    logic           frame_end;
    logic           frame_vis_end;              // end of the last visible line
    logic           byte_lo;
    color_t         border_color;
    hres_t          vid_left;
    hres_t          vid_right;
    logic           pa_blank;
    color_t         pa_colorbase;
    addr_t          pa_start_addr;
    word_t          pa_line_len;

    assign h_visible     = (h_count < hres_t'(`VID_H_VISIBLE));
    assign frame_vis_end = line_end && (v_count == vres_t'(`VID_V_VISIBLE - 1));

    video_timing u_timing (
        .clk(clk), .reset_i(reset_i),
        .h_count_o(h_count), .v_count_o(v_count),
        .h_state_next_o(h_state_next), .v_state_next_o(v_state_next),
        .v_visible_o(v_visible), .line_end_o(line_end), .frame_end_o(frame_end)
    );

    video_regs u_regs (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .intr_status_i(intr_status_i), .intr_signal_o(intr_signal_o),
        .frame_vis_end_i(frame_vis_end), .v_count_i(v_count), .v_visible_i(v_visible),
        .border_color_o(border_color), .vid_left_o(vid_left), .vid_right_o(vid_right),
        .pa_blank_o(pa_blank), .pa_colorbase_o(pa_colorbase),
        .pa_start_addr_o(pa_start_addr), .pa_line_len_o(pa_line_len)
    );

    bitmap_fetch u_fetch (
        .clk(clk), .reset_i(reset_i),
        .h_count_i(h_count), .v_visible_i(v_visible),
        .line_end_i(line_end), .frame_end_i(frame_end), .h_visible_i(h_visible),
        .pa_blank_i(pa_blank), .pa_start_addr_i(pa_start_addr), .pa_line_len_i(pa_line_len),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .byte_lo_o(byte_lo)
    );

    pixel_out u_pixel (
        .clk(clk), .reset_i(reset_i),
        .vram_data_i(vram_data_i), .byte_lo_i(byte_lo), .h_count_i(h_count),
        .h_state_next_i(h_state_next), .v_state_next_i(v_state_next),
        .border_color_i(border_color), .vid_left_i(vid_left), .vid_right_i(vid_right),
        .pa_blank_i(pa_blank), .pa_colorbase_i(pa_colorbase),
        .colorA_index_o(colorA_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

endmodule

`default_nettype wire

/* verification/video_gen_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "video_config.svh"

module video_gen_tb;

    localparam int FRAME_CYCLES   = `VID_H_TOTAL * `VID_V_TOTAL;
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 1000;
    // interrupt comes one cycle after the last visible count, first pixel shows two after its count
    localparam int IRQ_OFFSET     = (`VID_V_VISIBLE - 1) * `VID_H_TOTAL + `VID_H_VISIBLE - 2;
    localparam int MAX_ERROR_LINES = 10;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        reg_wr_i;
    logic [4:0]  reg_num_i;
    logic [15:0] reg_data_i;
    logic [15:0] reg_data_o;
    logic [3:0]  intr_status_i;
    logic [3:0]  intr_signal_o;
    logic        vram_sel_o;
    logic [15:0] vram_addr_o;
    logic [15:0] vram_data_i;
    logic [7:0]  colorA_index_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        dv_de_o;

    logic [15:0] vram [0:65535];                // video memory model
    logic        fetch_sel = 1'b0;
    logic [15:0] fetch_addr;
    logic [15:0] model_start;                   // playfield setup known to the model
    logic [15:0] model_stride;
    logic [7:0]  model_colorbase;
    integer      seed;
    int          cycle_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    video_gen u_video_gen (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .intr_status_i(intr_status_i), .intr_signal_o(intr_signal_o),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .colorA_index_o(colorA_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // memory answers in the cycle after the request
    always @(negedge clk) begin
        fetch_sel  = vram_sel_o;
        fetch_addr = vram_addr_o;
    end

    always @(posedge clk) begin
        #1;
        if (fetch_sel) begin
            vram_data_i = vram[fetch_addr];
        end
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual,
                                   inout int errs);
        if (errs < MAX_ERROR_LINES) begin
            $display("error %s: %s expected %0d actual %0d", test, what, expected, actual);
        end
        errs++;
    endtask

    task automatic finish_test(input string test, input int errs);
        if (errs == 0) begin
            $display("test %s: ok", test);
            pass_count++;
        end else begin
            $display("test %s: %0d errors", test, errs);
            fail_count++;
        end
    endtask

    task automatic write_reg(input logic [4:0] num, input logic [15:0] data);
        @(posedge clk);
        #1;
        reg_wr_i   = 1'b1;
        reg_num_i  = num;
        reg_data_i = data;
        @(posedge clk);
        #1;
        reg_wr_i = 1'b0;
    endtask

    task automatic check_readback(input string test, input logic [4:0] num,
                                  input logic [15:0] expected, inout int errs);
        @(posedge clk);
        #1;
        reg_num_i = num;
        @(posedge clk);
        @(negedge clk);                         // readback is registered
        if (reg_data_o !== expected) begin
            report_mismatch(test, $sformatf("register %0h", num), expected, reg_data_o, errs);
        end
    endtask

    task automatic wait_vsync_fall();
        logic vs_q;
        vs_q = 1'b0;
        @(negedge clk);
        while (!(vs_q && !vsync_o)) begin
            vs_q = vsync_o;
            @(negedge clk);
        end
    endtask

    function automatic logic [7:0] expected_pixel(input int y, input int n, input int left,
                                                  input int right, input logic blank,
                                                  input logic [7:0] border);
        logic [15:0] addr;
        logic [15:0] mem_word;
        if (blank || n < left || n >= right) begin
            return border;
        end
        addr     = 16'(model_start + y * model_stride + n / 2);
        mem_word = vram[addr];
        return ((n % 2 == 0) ? mem_word[15:8] : mem_word[7:0]) ^ model_colorbase;
    endfunction

    // checks the visible lines of the next frame, starting in vertical blank
    task automatic check_frame_pixels(input string test, input int left, input int right,
                                      input logic blank, input logic [7:0] border,
                                      inout int errs);
        int         y;
        int         n;
        logic [7:0] expected;
        y = 0;
        n = 0;
        while (y < `VID_V_VISIBLE) begin
            @(negedge clk);
            if (blank && vram_sel_o) begin
                report_mismatch(test, "vram_sel_o while blanked", 0, vram_sel_o, errs);
            end
            if (dv_de_o) begin
                expected = expected_pixel(y, n, left, right, blank, border);
                if (colorA_index_o !== expected) begin
                    report_mismatch(test, $sformatf("pixel %0d of line %0d", n, y),
                                    expected, colorA_index_o, errs);
                end
                n++;
            end else if (n != 0) begin
                y++;
                n = 0;
            end
        end
    endtask

    // runs from one vsync fall to the next
    task automatic check_frame_timing(inout int sync_errs, inout int irq_errs);
        int   cycles;
        int   vs_low;
        int   de_run;
        int   de_runs;
        int   hs_run;
        int   hs_runs;
        int   de_start;
        int   irq_at;
        int   irq_cycles;
        logic de_q;
        logic hs_q;
        logic vs_q;
        cycles     = 1;
        vs_low     = 1;
        de_run     = 0;
        de_runs    = 0;
        hs_run     = 0;
        hs_runs    = 0;
        de_start   = -1;
        irq_at     = -1;
        irq_cycles = 0;
        de_q       = dv_de_o;
        hs_q       = hsync_o;
        vs_q       = vsync_o;
        @(negedge clk);
        while (!(vs_q && !vsync_o)) begin
            cycles++;
            if (!vsync_o) begin
                vs_low++;
            end
            if (dv_de_o) begin
                de_run++;
                if (!de_q && de_start < 0) begin
                    de_start = cycle_count;     // first pixel of the frame
                end
            end else if (de_q) begin
                if (de_run != `VID_H_VISIBLE) begin
                    report_mismatch("sync counts", "dv_de_o cycles in a line",
                                    `VID_H_VISIBLE, de_run, sync_errs);
                end
                de_runs++;
                de_run = 0;
            end
            if (!hsync_o) begin
                hs_run++;
            end else if (!hs_q) begin
                if (hs_run != `VID_H_SYNC) begin
                    report_mismatch("sync counts", "hsync_o low cycles",
                                    `VID_H_SYNC, hs_run, sync_errs);
                end
                hs_runs++;
                hs_run = 0;
            end
            if (intr_signal_o[3]) begin
                irq_cycles++;
                if (irq_at < 0) begin
                    irq_at = cycle_count;
                end
            end
            de_q = dv_de_o;
            hs_q = hsync_o;
            vs_q = vsync_o;
            @(negedge clk);
        end
        if (cycles != FRAME_CYCLES) begin
            report_mismatch("sync counts", "frame cycles", FRAME_CYCLES, cycles, sync_errs);
        end
        if (vs_low != `VID_V_SYNC * `VID_H_TOTAL) begin
            report_mismatch("sync counts", "vsync_o low cycles",
                            `VID_V_SYNC * `VID_H_TOTAL, vs_low, sync_errs);
        end
        if (de_runs != `VID_V_VISIBLE) begin
            report_mismatch("sync counts", "visible lines", `VID_V_VISIBLE, de_runs, sync_errs);
        end
        if (hs_runs != `VID_V_TOTAL) begin
            report_mismatch("sync counts", "hsync pulses", `VID_V_TOTAL, hs_runs, sync_errs);
        end
        if (irq_cycles != 1) begin
            report_mismatch("interrupts", "frame interrupt cycles", 1, irq_cycles, irq_errs);
        end
        if (irq_at - de_start != IRQ_OFFSET) begin
            report_mismatch("interrupts", "frame interrupt offset",
                            IRQ_OFFSET, irq_at - de_start, irq_errs);
        end
    endtask

    // called in the cycle after the write strobe
    task automatic check_irq_pulse(input logic [3:0] bits, inout int errs);
        int         pulses;
        logic [3:0] seen;
        pulses = 0;
        seen   = 4'b0000;
        repeat (4) begin
            @(negedge clk);
            if (intr_signal_o !== 4'b0000) begin
                pulses++;
                seen = intr_signal_o;
            end
        end
        if (pulses != ((bits != 4'b0000) ? 1 : 0)) begin
            report_mismatch("interrupts", "write pulse cycles", (bits != 4'b0000), pulses, errs);
        end
        if (seen !== bits) begin
            report_mismatch("interrupts", "write pulse bits", bits, seen, errs);
        end
    endtask

    initial begin
        int          errs;
        int          sync_errs;
        int          irq_errs;
        int          pix_errs;
        int          left;
        int          right;
        logic [15:0] data [0:2];
        logic [7:0]  border;
        logic [3:0]  bits;

        seed          = 63276;
        reset_i       = 1'b1;
        reg_wr_i      = 1'b0;
        reg_num_i     = 5'h1f;                  // unused register number
        reg_data_i    = '0;
        vram_data_i   = '0;
        intr_status_i = 4'($random(seed));
        for (int i = 0; i < 65536; i++) begin
            vram[i] = 16'($random(seed));
        end

        errs = 0;
        repeat (9) @(posedge clk);
        @(negedge clk);
        if ({hsync_o, vsync_o, dv_de_o, vram_sel_o, intr_signal_o} !== 8'b1100_0000) begin
            report_mismatch("reset readback", "sync, enable, select and interrupt bits",
                            8'b1100_0000, {hsync_o, vsync_o, dv_de_o, vram_sel_o,
                            intr_signal_o}, errs);
        end
        @(posedge clk);
        #1;
        reset_i = 1'b0;
        check_readback("reset readback", `XR_VID_CTRL, {8'h08, 4'h0, intr_status_i}, errs);
        check_readback("reset readback", `XR_PA_LINE_LEN, 16'd80, errs);
        check_readback("reset readback", `XR_VID_HSIZE, 16'd640, errs);
        check_readback("reset readback", `XR_VID_VSIZE, 16'd480, errs);
        check_readback("reset readback", `XR_PA_GFX_CTRL, 16'h0080, errs);
        check_readback("reset readback", 5'h1f, 16'h0000, errs);
        finish_test("reset readback", errs);

        errs = 0;
        data[0] = 16'($random(seed));
        data[1] = 16'($random(seed));
        data[2] = 16'($random(seed));
        write_reg(`XR_PA_DISP_ADDR, data[0]);
        write_reg(`XR_PA_LINE_LEN, data[1]);
        write_reg(`XR_PA_GFX_CTRL, data[2]);
        check_readback("register readback", `XR_PA_DISP_ADDR, data[0], errs);
        check_readback("register readback", `XR_PA_LINE_LEN, data[1], errs);
        check_readback("register readback", `XR_PA_GFX_CTRL, data[2] & 16'hff80, errs);
        finish_test("register readback", errs);

        // full frame of bitmap pixels, timing measured alongside
        sync_errs       = 0;
        irq_errs        = 0;
        pix_errs        = 0;
        model_start     = 16'($random(seed));
        model_stride    = 16'($random(seed));
        model_colorbase = 8'($random(seed));
        wait_vsync_fall();
        fork
            check_frame_timing(sync_errs, irq_errs);
            begin
                write_reg(`XR_PA_DISP_ADDR, model_start);
                write_reg(`XR_PA_LINE_LEN, model_stride);
                write_reg(`XR_PA_GFX_CTRL, {model_colorbase, 8'h00});
                check_frame_pixels("pixel content", 0, `VID_H_VISIBLE, 1'b0,
                                   8'h08, pix_errs);
            end
        join
        finish_test("sync counts", sync_errs);
        finish_test("pixel content", pix_errs);

        errs   = 0;
        left   = $unsigned($random(seed)) % 320;
        right  = 320 + $unsigned($random(seed)) % 321;
        border = 8'($random(seed));
        bits   = 4'($random(seed));
        write_reg(`XR_VID_LEFT, 16'(left));
        write_reg(`XR_VID_RIGHT, 16'(right));
        write_reg(`XR_VID_CTRL, {border, 4'h0, bits});
        check_irq_pulse(bits, irq_errs);
        finish_test("interrupts", irq_errs);
        check_frame_pixels("border and blank", left, right, 1'b0, border, errs);
        write_reg(`XR_PA_GFX_CTRL, {model_colorbase, 8'h80});
        check_frame_pixels("border and blank", left, right, 1'b1, border, errs);
        finish_test("border and blank", errs);

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
hw/video_pkg.sv
hw/video_timing.sv
hw/video_regs.sv
hw/bitmap_fetch.sv
hw/pixel_out.sv
hw/video_gen.sv
verification/video_gen_tb.sv
